/* hw/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] word_t;

    typedef logic [5:0] hw_int_t;

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14
    } cp0_reg_e;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_e;

    typedef struct packed {
        word_t pc;
        word_t bad_addr;                 // Faulting data address
        logic  bd;                       // In a branch delay slot
        logic  inst_addr_err;
        logic  load_addr_err;
        logic  store_addr_err;
        logic  overflow;
        logic  syscall;
        logic  brk;
        logic  reserved_inst;
        logic  interrupt;
    } exc_report_t;

    typedef struct packed {
        logic     valid;
        cp0_reg_e addr;
        word_t    data;
    } cp0_write_t;

    localparam word_t STATUS_WMASK = 32'h0000ff03;   // IM7..0, EXL, IE
    localparam word_t CAUSE_WMASK  = 32'h00000300;   // Software IP bits only
    localparam word_t STATUS_RESET = 32'h00400000;   // BEV set

    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IE_BIT  = 0;
    localparam int CAUSE_BD_BIT   = 31;
    localparam int CAUSE_TI_BIT   = 30;

endpackage

/* hw/cp0_exc_collect.sv */
`timescale 1ns/1ps

module cp0_exc_collect (
    input  cp0_pkg::exc_report_t exc,
    input  logic                 stall,
    input  cp0_pkg::cp0_write_t  mtc0,
    output logic                 flush,
    output cp0_pkg::exc_code_e   exc_code,
    output cp0_pkg::cp0_write_t  wr
);
    import cp0_pkg::*;

    assign flush = exc.inst_addr_err
                 | exc.load_addr_err
                 | exc.store_addr_err
                 | exc.overflow
                 | exc.syscall
                 | exc.brk
                 | exc.reserved_inst
                 | exc.interrupt;

    // Highest priority first
    always_comb
    begin
        if (exc.inst_addr_err || exc.load_addr_err)
        begin
            exc_code = ADEL;
        end
        else if (exc.store_addr_err)
        begin
            exc_code = ADES;
        end
        else if (exc.overflow)
        begin
            exc_code = OV;
        end
        else if (exc.syscall)
        begin
            exc_code = SYS;
        end
        else if (exc.brk)
        begin
            exc_code = BP;
        end
        else if (exc.reserved_inst)
        begin
            exc_code = RI;
        end
        else
        begin
            exc_code = INT;                  // Interrupt or idle
        end
    end

    // A write dies with a stalled or flushed instruction
    always_comb
    begin
        wr       = mtc0;
        wr.valid = mtc0.valid && !stall && !flush;
    end

endmodule

/* hw/cp0_timer.sv */
`timescale 1ns/1ps

module cp0_timer (
    input  logic                clk,
    input  logic                resetn,
    input  cp0_pkg::cp0_write_t wr,
    output cp0_pkg::word_t      count,
    output cp0_pkg::word_t      compare,
    output logic                timer_pending
);
    import cp0_pkg::*;

    logic phase;                             // Half-rate tick
    logic armed;
    logic count_wr;
    logic compare_wr;

    assign count_wr   = wr.valid && (wr.addr == COUNT);
    assign compare_wr = wr.valid && (wr.addr == COMPARE);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            count <= '0;
            phase <= 1'b0;
        end
        else if (count_wr)
        begin
            count <= wr.data;
            phase <= 1'b0;                   // Restart the tick phase
        end
        else
        begin
            if (phase)
                count <= count + 32'd1;
            phase <= ~phase;
        end
    end

    // The match only counts once software has loaded Compare
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            compare       <= '0;
            armed         <= 1'b0;
            timer_pending <= 1'b0;
        end
        else if (compare_wr)
        begin
            compare       <= wr.data;
            armed         <= 1'b1;
            timer_pending <= 1'b0;           // Compare write acks the timer
        end
        else if (armed && (count == compare))
        begin
            timer_pending <= 1'b1;
        end
    end

endmodule

/* hw/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic                 clk,
    input  logic                 resetn,
    input  cp0_pkg::cp0_write_t  wr,
    input  logic                 flush,
    input  cp0_pkg::exc_code_e   exc_code,
    input  cp0_pkg::exc_report_t exc,
    input  logic                 eret,
    input  cp0_pkg::hw_int_t     hw_int,
    input  logic                 timer_pending,
    output cp0_pkg::word_t       status,
    output cp0_pkg::word_t       cause,
    output cp0_pkg::word_t       epc,
    output cp0_pkg::word_t       badvaddr
);
    import cp0_pkg::*;

    logic      cause_bd;
    logic [1:0] cause_sw;                    // Software interrupt bits 9:8
    hw_int_t   cause_hw;
    exc_code_e cause_code;
    word_t     status_wdata;
    word_t     cause_wdata;
    logic      take_exc;

    assign status_wdata = (wr.data & STATUS_WMASK) | (status & ~STATUS_WMASK);
    assign cause_wdata  = wr.data & CAUSE_WMASK;
    assign take_exc     = flush && !status[STATUS_EXL_BIT];   // Not nested

    always_ff @(posedge clk)
    begin
        if (!resetn)
            status <= STATUS_RESET;
        else if (flush)
            status[STATUS_EXL_BIT] <= 1'b1;
        else if (eret)
            status[STATUS_EXL_BIT] <= 1'b0;
        else if (wr.valid && wr.addr == STATUS)
            status <= status_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            cause_bd   <= 1'b0;
            cause_sw   <= 2'b00;
            cause_hw   <= '0;
            cause_code <= INT;
        end
        else
        begin
            cause_hw <= hw_int;              // Sampled every cycle
            if (take_exc)
            begin
                cause_bd   <= exc.bd;
                cause_code <= exc_code;
            end
            else if (wr.valid && wr.addr == CAUSE)
            begin
                cause_sw <= cause_wdata[9:8];
            end
        end
    end

    // Timer flag also shows up as IP7
    assign cause = {cause_bd, timer_pending, 14'b0,
                    cause_hw[5] | timer_pending, cause_hw[4:0],
                    cause_sw, 1'b0, cause_code, 2'b00};

    always_ff @(posedge clk)
    begin
        if (!resetn)
            epc <= '0;
        else if (take_exc)
            epc <= (exc.bd && !exc.inst_addr_err) ? exc.pc - 32'd4 : exc.pc;
        else if (wr.valid && wr.addr == EPC)
            epc <= wr.data;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            badvaddr <= '0;
        else if (exc.load_addr_err || exc.store_addr_err)
            badvaddr <= exc.bad_addr;
        else if (exc.inst_addr_err)
            badvaddr <= exc.pc;              // Fetch address was bad
        else if (wr.valid && wr.addr == BADVADDR)
            badvaddr <= wr.data;
    end

endmodule

/* hw/cp0_read_irq.sv */
`timescale 1ns/1ps

module cp0_read_irq (
    input  cp0_pkg::word_t    status,
    input  cp0_pkg::word_t    cause,
    input  cp0_pkg::word_t    epc,
    input  cp0_pkg::word_t    badvaddr,
    input  cp0_pkg::word_t    count,
    input  cp0_pkg::word_t    compare,
    input  cp0_pkg::cp0_reg_e rd_addr,
    output cp0_pkg::word_t    rd_data,
    output logic              irq
);
    import cp0_pkg::*;

    logic ip_hit;

    always_comb
    begin
        case (rd_addr)
            BADVADDR: rd_data = badvaddr;
            COUNT:    rd_data = count;
            COMPARE:  rd_data = compare;
            STATUS:   rd_data = status;
            CAUSE:    rd_data = cause;
            EPC:      rd_data = epc;
            default:  rd_data = '0;          // Unimplemented register
        endcase
    end

    // Pending line with its IM bit, or the timer under IM7
    assign ip_hit = (|(cause[15:8] & status[15:8]))
                  || (cause[CAUSE_TI_BIT] && status[15]);

    assign irq = ip_hit && status[STATUS_IE_BIT] && !status[STATUS_EXL_BIT];

endmodule

/* hw/cp0_top.sv */
`timescale 1ns/1ps

module cp0_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  cp0_pkg::exc_report_t exc,
    input  logic                 stall,
    input  logic                 eret,
    input  cp0_pkg::cp0_write_t  mtc0,
    input  cp0_pkg::hw_int_t     hw_int,
    input  cp0_pkg::cp0_reg_e    rd_addr,
    output cp0_pkg::word_t       rd_data,
    output logic                 flush,
    output cp0_pkg::exc_code_e   exc_code,
    output logic                 irq,
    output cp0_pkg::word_t       epc
);
    import cp0_pkg::*;

    cp0_write_t wr;                          // Qualified MTC0
    word_t      status;
    word_t      cause;
    word_t      badvaddr;
    word_t      count;
    word_t      compare;
    logic       timer_pending;

    cp0_exc_collect u_collect (
        .exc      (exc),
        .stall    (stall),
        .mtc0     (mtc0),
        .flush    (flush),
        .exc_code (exc_code),
        .wr       (wr)
    );

    cp0_timer u_timer (
        .clk           (clk),
        .resetn        (resetn),
        .wr            (wr),
        .count         (count),
        .compare       (compare),
        .timer_pending (timer_pending)
    );

    cp0_regs u_regs (
        .clk           (clk),
        .resetn        (resetn),
        .wr            (wr),
        .flush         (flush),
        .exc_code      (exc_code),
        .exc           (exc),
        .eret          (eret),
        .hw_int        (hw_int),
        .timer_pending (timer_pending),
        .status        (status),
        .cause         (cause),
        .epc           (epc),
        .badvaddr      (badvaddr)
    );

    cp0_read_irq u_read (
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badvaddr (badvaddr),
        .count    (count),
        .compare  (compare),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .irq      (irq)
    );

endmodule

/* tests/cp0_props.sv */
`timescale 1ns/1ps

module cp0_props (
    input logic                clk,
    input logic                resetn,
    input logic                stall,
    input logic                eret,
    input cp0_pkg::cp0_write_t mtc0,
    input logic                flush,
    input logic                irq,
    input cp0_pkg::word_t      status,
    input cp0_pkg::word_t      cause,
    input cp0_pkg::word_t      epc,
    input cp0_pkg::word_t      compare
);
    import cp0_pkg::*;

    // Exception entry always raises EXL
    a_flush_sets_exl: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> status[STATUS_EXL_BIT])
        else $error("EXL not set after flush");

    a_stall_blocks_write: assert property (@(posedge clk) disable iff (!resetn)
        (mtc0.valid && stall && !flush && !eret)
        |=> ($stable(status) && $stable(epc) && $stable(compare) && $stable(cause[9:8])))
        else $error("Register changed on a stalled MTC0");

    a_no_irq_in_exl: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> !irq)
        else $error("irq high after exception entry");

endmodule

/* tests/cp0_tb.sv */
`timescale 1ns/1ps

module cp0_tb;
    import cp0_pkg::*;

    localparam int TIMEOUT = 200;               // Cycles per wait

    logic        clk;
    logic        resetn;
    exc_report_t exc;
    logic        stall;
    logic        eret;
    cp0_write_t  mtc0;
    hw_int_t     hw_int;
    cp0_reg_e    rd_addr;
    word_t       rd_data;
    logic        flush;
    exc_code_e   exc_code;
    logic        irq;
    word_t       epc;
    int          errors;
    int          checks;
    logic        timed_out;

    cp0_top dut0 (
        .clk      (clk),
        .resetn   (resetn),
        .exc      (exc),
        .stall    (stall),
        .eret     (eret),
        .mtc0     (mtc0),
        .hw_int   (hw_int),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .flush    (flush),
        .exc_code (exc_code),
        .irq      (irq),
        .epc      (epc)
    );

    bind cp0_top cp0_props props0 (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stall),
        .eret    (eret),
        .mtc0    (mtc0),
        .flush   (flush),
        .irq     (irq),
        .status  (status),
        .cause   (cause),
        .epc     (epc),
        .compare (compare)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Reference priority with flags in report order {bd, iae, lae, sae, ov, sys, brk, ri, int}
    function automatic exc_code_e expected_code(input logic [8:0] f);
        if (f[7] || f[6])
            return ADEL;
        else if (f[5])
            return ADES;
        else if (f[4])
            return OV;
        else if (f[3])
            return SYS;
        else if (f[2])
            return BP;
        else if (f[1])
            return RI;
        return INT;
    endfunction

    task automatic wait_until(input logic want_irq, input logic need_ti);
        int n;
        n = 0;
        @(negedge clk);
        while ((irq !== want_irq || (need_ti && rd_data[CAUSE_TI_BIT] !== 1'b1)) && !timed_out)
        begin
            n++;
            if (n > TIMEOUT)
            begin
                $display("Timeout at %0t: irq never reached %b", $time, want_irq);
                errors++;
                timed_out = 1'b1;
            end
            else
            begin
                @(negedge clk);
            end
        end
    endtask

    task automatic run_case(input word_t op, input word_t a, input word_t b, input word_t c,
                            input word_t reg_n, input word_t exp_val, input word_t exp_irq);
        cp0_reg_e rd;
        rd = cp0_reg_e'(reg_n[4:0]);
        @(posedge clk);
        #2;
        rd_addr = (op == 32'd5) ? CAUSE : rd;   // Timer wait watches Cause
        case (op)
            32'd1:
            begin
                mtc0.valid = 1'b1;
                mtc0.addr  = cp0_reg_e'(a[4:0]);
                mtc0.data  = b;
                stall      = c[0];
            end
            32'd2: exc = {b, c, a[8:0]};
            32'd3: eret = 1'b1;
            32'd4: hw_int = a[5:0];
            default: ;
        endcase
        if (op == 32'd2)
        begin
            @(negedge clk);
            check_value(word_t'(flush), 32'd1, "flush on exception");
            check_value(word_t'(exc_code), word_t'(expected_code(a[8:0])), "exc_code");
        end
        else if (op == 32'd4 || op == 32'd5)
        begin
            wait_until(exp_irq[0], op == 32'd5);
        end
        if (!timed_out)
        begin
            @(posedge clk);
            #2;
            exc     = '0;
            mtc0    = '0;
            stall   = 1'b0;
            eret    = 1'b0;
            rd_addr = rd;
            @(negedge clk);
            if (op == 32'd5)
                check_value(word_t'(rd_data >= exp_val), 32'd1, "Count past Compare");
            else
                check_value(rd_data, exp_val, $sformatf("register %0d", reg_n));
            if (rd == EPC)
                check_value(epc, exp_val, "epc port");
            check_value(word_t'(irq), exp_irq, "irq");
        end
    endtask

    initial
    begin
        int    fd;
        int    rc;
        int    n;
        int    ran;
        string line;
        word_t op;
        word_t a;
        word_t b;
        word_t c;
        word_t reg_n;
        word_t exp_val;
        word_t exp_irq;
        errors    = 0;
        checks    = 0;
        ran       = 0;
        timed_out = 1'b0;
        resetn    = 1'b0;
        exc       = '0;
        stall     = 1'b0;
        eret      = 1'b0;
        mtc0      = '0;
        hw_int    = '0;
        rd_addr   = STATUS;
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b1;
        @(negedge clk);
        check_value(word_t'(flush), 32'd0, "flush after reset");
        check_value(word_t'(irq), 32'd0, "irq after reset");
        fd = $fopen("tests/cp0_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open tests/cp0_cases.txt");
            errors++;
        end
        else
        begin
            while (!timed_out && !$feof(fd))
            begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 0 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                op, a, b, c, reg_n, exp_val, exp_irq);
                    if (n == 7)
                    begin
                        run_case(op, a, b, c, reg_n, exp_val, exp_irq);
                        ran++;
                    end
                end
            end
            $fclose(fd);
            if (ran == 0)
            begin
                $display("No cases were read from tests/cp0_cases.txt");
                errors++;
            end
        end
        $display("%0d cases, %0d checks, %0d errors", ran, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* tests/cp0_cases.txt */
# op a b c reg expected irq, all hex; reg is read one cycle after the op
# op 0 read, 1 mtc0 a=reg b=data c=stall, 2 exception a=bd+flags b=pc c=bad_addr, 3 eret, 4 hw_int a=lines, 5 timer wait
0 0 0 0 c 00400000 0
0 0 0 0 e 00000000 0
1 c ffffffff 0 c 0040ff03 0
1 d ffffffff 0 d 00000300 0
1 c 00000000 1 c 0040ff03 0
1 c 00000000 0 c 00400000 0
2 11c 00001000 00000000 e 00000ffc 0
0 0 0 0 d 80000330 0
3 0 0 0 c 00400000 0
2 060 00002000 00001234 8 00001234 0
2 180 00003000 00000000 e 00002000 0
0 0 0 0 8 00003000 0
3 0 0 0 c 00400000 0
1 c 00000401 0 c 00400401 0
4 01 0 0 d 00000710 1
2 001 00004000 00000000 e 00004000 0
1 c 00008001 0 c 00408001 0
1 b 00000100 0 b 00000100 0
1 9 000000fd 0 9 000000fd 0
5 0 0 0 9 00000100 1
0 0 0 0 d 40008700 1
1 b 00000200 0 d 00000700 0
0 0 0 0 1 00000000 0

/* filelist.f */
hw/cp0_pkg.sv
hw/cp0_exc_collect.sv
hw/cp0_timer.sv
hw/cp0_regs.sv
hw/cp0_read_irq.sv
hw/cp0_top.sv
tests/cp0_props.sv
tests/cp0_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CP0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cp0_tb -f filelist.f -o cp0_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cp0_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
